// File: Makefile
# Verilator build and run of the branch subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_branch_subsys
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# exit status of the model is the verdict
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_bru_model.svh
`ifndef TB_BRU_MODEL_SVH
`define TB_BRU_MODEL_SVH

// expected redirect for one legal branch request
function automatic bru_pkg::bru_res_t model_branch(input bru_pkg::bru_req_t r);
   bru_pkg::bru_res_t            e;
   logic [la_isa_pkg::GRLEN-1:0] base;
   logic [la_isa_pkg::GRLEN-1:0] seq;
   logic                         t;
   // word aligned pc and the next instruction
   base      = r.pc;
   base[1:0] = 2'b00;
   seq       = base + 4;
   case (r.op)
      la_isa_pkg::BRU_EQZ: t = (r.a == '0);
      la_isa_pkg::BRU_NEZ: t = (r.a != '0);
      la_isa_pkg::BRU_EQ:  t = (r.a == r.b);
      la_isa_pkg::BRU_NE:  t = (r.a != r.b);
      la_isa_pkg::BRU_LT:  t = ($signed(r.a) < $signed(r.b));
      la_isa_pkg::BRU_GE:  t = ($signed(r.a) >= $signed(r.b));
      la_isa_pkg::BRU_LTU: t = (r.a < r.b);
      la_isa_pkg::BRU_GEU: t = (r.a >= r.b);
      // jirl, bl and b are unconditional
      default:             t = 1'b1;
   endcase
   if (r.op == la_isa_pkg::BRU_JIRL) begin
      e.target = r.a + r.offset;
   end else begin
      e.target = t ? base + r.offset : seq;
   end
   e.taken    = t;
   e.link_pc  = seq;
   e.link_wen = (r.op == la_isa_pkg::BRU_JIRL) || (r.op == la_isa_pkg::BRU_BL);
   return e;
endfunction

`endif

// File: bench/tb_branch_subsys.sv
`default_nettype none
`timescale 1ns/1ns

`include "tb_bru_model.svh"

module tb_branch_subsys
   import la_isa_pkg::*;
   import bru_pkg::*;
();

   localparam int W          = GRLEN;
   localparam int N_RANDOM   = 3000;
   localparam int WAIT_LIMIT = 400;

   logic         clk;
   logic         rst;
   logic         issue_valid;
   logic [3:0]   issue_op;
   logic [W-1:0] issue_a;
   logic [W-1:0] issue_b;
   logic [W-1:0] issue_pc;
   logic [W-1:0] issue_offset;
   logic         redirect_stall;
   logic         issue_busy;
   logic         issue_illegal;
   logic         redirect_valid;
   logic [W-1:0] redirect_target;
   logic         redirect_taken;
   logic [W-1:0] link_pc;
   logic         link_wen;

   // expected results in issue order
   bru_res_t    exp_q[$];
   logic [31:0] lcg_state;
   // issue history, current and previous cycle
   logic        iss_cur;
   logic        iss_prev;
   logic        ill_cur;
   logic        ill_prev;
   // busy as seen at the last falling edge
   logic        busy_neg;
   logic        seen_busy;
   logic        stall_on;
   int          stall_left;
   string       test_name;

   branch_subsys #(.W(W), .DEPTH(BRU_QDEPTH)) u_dut (
      .clk             (clk),
      .rst             (rst),
      .issue_valid     (issue_valid),
      .issue_op        (issue_op),
      .issue_a         (issue_a),
      .issue_b         (issue_b),
      .issue_pc        (issue_pc),
      .issue_offset    (issue_offset),
      .redirect_stall  (redirect_stall),
      .issue_busy      (issue_busy),
      .issue_illegal   (issue_illegal),
      .redirect_valid  (redirect_valid),
      .redirect_target (redirect_target),
      .redirect_taken  (redirect_taken),
      .link_pc         (link_pc),
      .link_wen        (link_wen)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // upper half of the lcg state, the low bits cycle too fast
   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   function automatic logic [W-1:0] rand_word();
      return W'({lcg_next(), lcg_next()});
   endfunction

   // corner values dominate so compares hit the boundaries
   function automatic logic [W-1:0] pick_operand();
      case (lcg_next() % 8)
         0:       return '0;
         1:       return {1'b1, {(W-1){1'b0}}};
         2:       return {1'b0, {(W-1){1'b1}}};
         3:       return '1;
         4:       return W'(1);
         default: return rand_word();
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "testbench stopped at first error");
   endtask

   task automatic compare_res(input string name, input bru_res_t exp, input bru_res_t act);
      string exp_s;
      string act_s;
      if (act !== exp) begin
         exp_s = $sformatf("target=%h taken=%b link_pc=%h link_wen=%b",
                           exp.target, exp.taken, exp.link_pc, exp.link_wen);
         act_s = $sformatf("target=%h taken=%b link_pc=%h link_wen=%b",
                           act.target, act.taken, act.link_pc, act.link_wen);
         abort_run($sformatf("CHECK FAILED %s: expected %s actual %s", name, exp_s, act_s));
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
      end
   endtask

   // one clock of stimulus, returns at the falling edge
   task automatic step(input logic valid, input logic [3:0] op, input logic [W-1:0] a,
                       input logic [W-1:0] b, input logic [W-1:0] pc, input logic [W-1:0] off);
      bru_req_t r;
      @(posedge clk);
      ill_prev = ill_cur;
      ill_cur  = valid && (op > 4'd10);
      iss_prev = iss_cur;
      iss_cur  = valid;
      // stall bursts, mostly short, now and then long
      if (!stall_on) begin
         stall_left = 0;
      end else if (stall_left == 0) begin
         case (lcg_next() % 32)
            0:          stall_left = 20 + int'(lcg_next() % 24);
            1, 2, 3, 4: stall_left = 1 + int'(lcg_next() % 6);
            default:    stall_left = 0;
         endcase
      end
      redirect_stall <= (stall_left != 0);
      if (stall_left != 0) begin
         stall_left--;
      end
      issue_valid  <= valid;
      issue_op     <= op;
      issue_a      <= a;
      issue_b      <= b;
      issue_pc     <= pc;
      issue_offset <= off;
      if (valid && op <= 4'd10) begin
         r = '{op: bru_op_e'(op), a: a, b: b, pc: pc, offset: off};
         exp_q.push_back(model_branch(r));
      end
      @(negedge clk);
      busy_neg  = issue_busy;
      seen_busy = seen_busy | issue_busy;
   endtask

   task automatic idle();
      step(1'b0, 4'd0, '0, '0, '0, '0);
   endtask

   // redirect scoreboard and illegal pulse, every falling edge out of reset
   initial begin
      bru_res_t act;
      forever begin
         @(negedge clk);
         if (!rst) begin
            compare_flag($sformatf("%s issue_illegal", test_name), ill_prev, issue_illegal);
            if (redirect_valid) begin
               act = '{target: redirect_target, taken: redirect_taken,
                       link_pc: link_pc, link_wen: link_wen};
               if (exp_q.size() == 0) begin
                  abort_run("redirect_valid seen with no branch outstanding");
               end else begin
                  compare_res(test_name, exp_q.pop_front(), act);
               end
            end else begin
               // flags are gated by valid
               compare_flag($sformatf("%s idle redirect_taken", test_name), 1'b0,
                            redirect_taken);
               compare_flag($sformatf("%s idle link_wen", test_name), 1'b0, link_wen);
            end
         end
      end
   end

   initial begin
      logic [3:0]   op;
      logic [W-1:0] a;
      int           t;
      lcg_state      = 32'd24;
      rst            = 1'b1;
      issue_valid    = 1'b0;
      issue_op       = 4'd0;
      issue_a        = '0;
      issue_b        = '0;
      issue_pc       = '0;
      issue_offset   = '0;
      redirect_stall = 1'b0;
      iss_cur        = 1'b0;
      iss_prev       = 1'b0;
      ill_cur        = 1'b0;
      ill_prev       = 1'b0;
      busy_neg       = 1'b0;
      seen_busy      = 1'b0;
      stall_on       = 1'b0;
      stall_left     = 0;
      test_name      = "reset";
      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
         if (i == 15) begin
            rst <= 1'b0;
         end
         @(negedge clk);
         compare_flag("reset redirect_valid", 1'b0, redirect_valid);
         compare_flag("reset issue_busy", 1'b0, issue_busy);
         compare_flag("reset issue_illegal", 1'b0, issue_illegal);
      end
      repeat (3) begin
         idle();
         compare_flag("after reset issue_busy", 1'b0, issue_busy);
      end

      // geu, jirl, bl, b through an empty pipeline
      test_name = "latency";
      for (int k = 7; k <= 10; k++) begin
         step(1'b1, 4'(k), pick_operand(), pick_operand(), rand_word(), rand_word());
         idle();
         compare_flag("latency cycle 1", 1'b0, redirect_valid);
         idle();
         compare_flag("latency cycle 2", 1'b0, redirect_valid);
         idle();
         compare_flag("latency cycle 3", 1'b1, redirect_valid);
         idle();
      end

      // no issue two cycles after an issue keeps the queue from overflowing
      test_name = "random";
      stall_on  = 1'b1;
      for (int n = 0; n < N_RANDOM; n++) begin
         if (!busy_neg && !iss_prev && (lcg_next() % 4 != 0)) begin
            if (lcg_next() % 16 == 0) begin
               op = 4'd11 + 4'(lcg_next() % 5);
            end else begin
               op = 4'(lcg_next() % 11);
            end
            a = pick_operand();
            step(1'b1, op, a, (lcg_next() % 4 == 0) ? a : pick_operand(),
                 rand_word(), rand_word());
         end else begin
            idle();
         end
      end

      test_name = "drain";
      stall_on  = 1'b0;
      t         = 0;
      while (exp_q.size() != 0 && t < WAIT_LIMIT) begin
         idle();
         t++;
      end
      // quiet cycles catch a duplicated redirect
      repeat (8) begin
         idle();
      end
      if (exp_q.size() != 0) begin
         abort_run($sformatf("timeout in drain, %0d results never came out", exp_q.size()));
      end else if (!seen_busy) begin
         abort_run("issue_busy never rose while the queue was stalled");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: design/branch.sv
`default_nettype none
`timescale 1ns/1ns

module branch
   import la_isa_pkg::*;
   import bru_pkg::*;
#(
   parameter int W = GRLEN
) (
   input  bru_op_e      op,
   input  logic [W-1:0] a,
   input  logic [W-1:0] b,
   input  logic [W-1:0] pc,
   input  logic [W-1:0] offset,
   output bru_res_t     res
);

   // opcode decode
   logic op_eqz;
   logic op_nez;
   logic op_eq;
   logic op_ne;
   logic op_lt;
   logic op_ge;
   logic op_ltu;
   logic op_geu;
   logic op_jirl;
   logic op_bl;

   // condition needs
   logic need_ltx;
   logic need_gex;
   logic cmp_unsigned;

   // compare results
   logic lt_u;
   logic lt_s;
   logic cond_lt;
   logic cond_eq;
   logic cond_eqz;
   logic take;

   logic [W-1:0] target_next;
   logic [W-1:0] target_true;
   logic [W-1:0] target_jr;

   assign op_eqz  = (op == BRU_EQZ);
   assign op_nez  = (op == BRU_NEZ);
   assign op_eq   = (op == BRU_EQ);
   assign op_ne   = (op == BRU_NE);
   assign op_lt   = (op == BRU_LT);
   assign op_ge   = (op == BRU_GE);
   assign op_ltu  = (op == BRU_LTU);
   assign op_geu  = (op == BRU_GEU);
   assign op_jirl = (op == BRU_JIRL);
   assign op_bl   = (op == BRU_BL);

   // ge is the inverse of lt
   assign need_ltx     = op_lt || op_ltu;
   assign need_gex     = op_ge || op_geu;
   assign cmp_unsigned = op_ltu || op_geu;

   assign lt_u     = (a < b);
   // sign bit decides when the signs differ
   assign lt_s     = (a[W-1] && !b[W-1]) || (lt_u && (a[W-1] == b[W-1]));
   assign cond_lt  = cmp_unsigned ? lt_u : lt_s;
   assign cond_eq  = (a == b);
   assign cond_eqz = (a == '0);

   // jumps need no condition, so they always take
   assign take = (!op_eqz   || cond_eqz)
              && (!op_nez   || !cond_eqz)
              && (!op_eq    || cond_eq)
              && (!op_ne    || !cond_eq)
              && (!need_ltx || cond_lt)
              && (!need_gex || !cond_lt);

   // sequential pc, word aligned
   assign target_next = {pc[W-1:2] + (W-2)'(1), 2'b00};
   // pc relative target
   assign target_true = {pc[W-1:2], 2'b00} + offset;
   // register indirect target
   assign target_jr   = a + offset;

   always_comb begin
      res.target   = op_jirl ? target_jr : (take ? target_true : target_next);
      res.taken    = take;
      // link is the return address in every case
      res.link_pc  = target_next;
      res.link_wen = op_jirl || op_bl;
   end

endmodule

`default_nettype wire

// File: design/branch_issue.sv
`default_nettype none
`timescale 1ns/1ns

module branch_issue
   import la_isa_pkg::*;
   import bru_pkg::*;
#(
   parameter int W = GRLEN
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         issue_valid,
   input  logic [3:0]   issue_op,
   input  logic [W-1:0] issue_a,
   input  logic [W-1:0] issue_b,
   input  logic [W-1:0] issue_pc,
   input  logic [W-1:0] issue_offset,
   input  logic         q_full,
   output logic         issue_busy,
   output logic         issue_illegal,
   bru_req_if.src       out
);

   bru_op_e  op_in;
   logic     op_legal;
   logic     accept;
   bru_req_t req_q;
   logic     put_q;
   logic     illegal_q;

   // raw code seen as an opcode
   assign op_in    = bru_op_e'(issue_op);
   // anything past BRU_B is undefined
   assign op_legal = op_in inside {BRU_EQZ, BRU_NEZ, BRU_EQ, BRU_NE, BRU_LT, BRU_GE,
                                   BRU_LTU, BRU_GEU, BRU_JIRL, BRU_BL, BRU_B};

   // queue near full holds off the front end
   assign issue_busy = q_full;
   assign accept     = issue_valid && !issue_busy;

   // strobes, one cycle after the sample
   always_ff @(posedge clk) begin
      if (rst) begin
         put_q     <= 1'b0;
         illegal_q <= 1'b0;
      end else begin
         put_q     <= accept && op_legal;
         illegal_q <= accept && !op_legal;
      end
   end

   // operand latch
   always_ff @(posedge clk) begin
      if (accept && op_legal) begin
         req_q <= '{op: op_in, a: issue_a, b: issue_b, pc: issue_pc, offset: issue_offset};
      end
   end

   assign out.req       = req_q;
   assign out.put       = put_q;
   assign issue_illegal = illegal_q;

   // front end must wait out busy
   a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
      issue_busy |-> !issue_valid)
      else $error("branch_issue: issue_valid while issue_busy");

endmodule

`default_nettype wire

// File: design/branch_queue.sv
`default_nettype none
`timescale 1ns/1ns

module branch_queue
   import la_isa_pkg::*;
   import bru_pkg::*;
#(
   parameter int W     = GRLEN,
   parameter int DEPTH = BRU_QDEPTH
) (
   input  logic   clk,
   input  logic   rst,
   bru_req_if.dst wr,
   bru_req_if.rs  rd,
   output logic   q_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   bru_req_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // wrap at DEPTH, not only at a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr.put) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (rd.take) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         // put and take together leave count alone
         case ({wr.put, rd.take})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (wr.put) begin
         mem[wr_ptr] <= wr.req;
      end
   end

   // head read straight from the array
   assign rd.req   = mem[rd_ptr];
   assign rd.avail = (count != '0);
   // one slot kept for the entry in the issue register
   assign q_full   = (count >= CNT_W'(DEPTH - 1));

   // issue throttle must prevent overflow
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      wr.put |-> (count != CNT_W'(DEPTH) || rd.take))
      else $error("branch_queue: put at full occupancy");

   // consumer only takes a valid head
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      rd.take |-> (count != '0))
      else $error("branch_queue: take while empty");

endmodule

`default_nettype wire

// File: design/branch_retire.sv
`default_nettype none
`timescale 1ns/1ns

module branch_retire
   import la_isa_pkg::*;
   import bru_pkg::*;
#(
   parameter int W = GRLEN
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         redirect_stall,
   bru_req_if.rd        in,
   output logic         redirect_valid,
   output logic [W-1:0] redirect_target,
   output logic         redirect_taken,
   output logic [W-1:0] link_pc,
   output logic         link_wen
);

   bru_res_t res_c;
   bru_res_t res_q;
   logic     take;
   logic     valid_q;

   // pop the head unless the front end stalls
   assign take    = in.avail && !redirect_stall;
   assign in.take = take;

   // head request resolved this cycle
   branch #(
      .W (W)
   ) u_branch (
      .op     (in.req.op),
      .a      (in.req.a),
      .b      (in.req.b),
      .pc     (in.req.pc),
      .offset (in.req.offset),
      .res    (res_c)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= take;
      end
   end

   // redirect payload
   always_ff @(posedge clk) begin
      if (take) begin
         res_q <= res_c;
      end
   end

   assign redirect_valid  = valid_q;
   assign redirect_target = res_q.target;
   // flags only count with a valid redirect
   assign redirect_taken  = res_q.taken && valid_q;
   assign link_pc         = res_q.link_pc;
   assign link_wen        = res_q.link_wen && valid_q;

   // issue filters illegal codes, so none may reach the head
   a_legal_head: assert property (@(posedge clk) disable iff (rst)
      take |-> (in.req.op inside {BRU_EQZ, BRU_NEZ, BRU_EQ, BRU_NE, BRU_LT, BRU_GE,
                                  BRU_LTU, BRU_GEU, BRU_JIRL, BRU_BL, BRU_B}))
      else $error("branch_retire: illegal opcode taken from the queue head");

endmodule

`default_nettype wire

// File: design/branch_subsys.sv
`default_nettype none
`timescale 1ns/1ns

module branch_subsys
   import la_isa_pkg::*;
   import bru_pkg::*;
#(
   parameter int W     = GRLEN,
   parameter int DEPTH = BRU_QDEPTH
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         issue_valid,
   input  logic [3:0]   issue_op,
   input  logic [W-1:0] issue_a,
   input  logic [W-1:0] issue_b,
   input  logic [W-1:0] issue_pc,
   input  logic [W-1:0] issue_offset,
   input  logic         redirect_stall,
   output logic         issue_busy,
   output logic         issue_illegal,
   output logic         redirect_valid,
   output logic [W-1:0] redirect_target,
   output logic         redirect_taken,
   output logic [W-1:0] link_pc,
   output logic         link_wen
);

   // issue register to queue
   bru_req_if #(.W(W)) issue_q ();
   // queue head to retire
   bru_req_if #(.W(W)) queue_r ();

   // occupancy level back to issue
   logic q_full;

   branch_issue #(
      .W (W)
   ) u_issue (
      .clk           (clk),
      .rst           (rst),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .issue_a       (issue_a),
      .issue_b       (issue_b),
      .issue_pc      (issue_pc),
      .issue_offset  (issue_offset),
      .q_full        (q_full),
      .issue_busy    (issue_busy),
      .issue_illegal (issue_illegal),
      .out           (issue_q.src)
   );

   branch_queue #(
      .W     (W),
      .DEPTH (DEPTH)
   ) u_queue (
      .clk    (clk),
      .rst    (rst),
      .wr     (issue_q.dst),
      .rd     (queue_r.rs),
      .q_full (q_full)
   );

   branch_retire #(
      .W (W)
   ) u_retire (
      .clk             (clk),
      .rst             (rst),
      .redirect_stall  (redirect_stall),
      .in              (queue_r.rd),
      .redirect_valid  (redirect_valid),
      .redirect_target (redirect_target),
      .redirect_taken  (redirect_taken),
      .link_pc         (link_pc),
      .link_wen        (link_wen)
   );

endmodule

`default_nettype wire

// File: design/bru_pkg.sv
`default_nettype none

package bru_pkg;

   import la_isa_pkg::*;

   // one branch as it waits for resolution
   typedef struct packed {
      bru_op_e          op;
      logic [GRLEN-1:0] a;
      logic [GRLEN-1:0] b;
      logic [GRLEN-1:0] pc;
      logic [GRLEN-1:0] offset;
   } bru_req_t;

   // resolved branch, the redirect payload
   typedef struct packed {
      logic [GRLEN-1:0] target;
      logic             taken;
      logic [GRLEN-1:0] link_pc;
      logic             link_wen;
   } bru_res_t;

   // default entries in the branch queue
   parameter int BRU_QDEPTH = 4;

endpackage

`default_nettype wire

// File: design/bru_req_if.sv
`default_nettype none
`timescale 1ns/1ns

interface bru_req_if
   import la_isa_pkg::*;
   import bru_pkg::*;
#(
   parameter int W = GRLEN
) ();

   // request payload
   bru_req_t req;
   // write strobe from the issue stage
   logic     put;
   // head entry valid, a level
   logic     avail;
   // head entry consumed this cycle
   logic     take;

   // struct fields are sized by GRLEN
   if (W != GRLEN) begin : g_width_chk
      $error("bru_req_if: W (%0d) differs from GRLEN (%0d)", W, GRLEN);
   end

   // producer side
   modport src (output req, output put);
   // queue write side
   modport dst (input req, input put);
   // consumer side
   modport rd (input req, input avail, output take);
   // queue read side
   modport rs (output req, output avail, input take);

endinterface

`default_nettype wire

// File: design/la_isa_pkg.sv
`default_nettype none

package la_isa_pkg;

   // general register and address width
   parameter int GRLEN = 32;

   // branch opcodes as decoded by the front end
   // codes 11 to 15 never reach the branch unit
   typedef enum logic [3:0] {
      // compare a with zero
      BRU_EQZ  = 4'd0,
      BRU_NEZ  = 4'd1,
      // compare a with b
      BRU_EQ   = 4'd2,
      BRU_NE   = 4'd3,
      // signed compare
      BRU_LT   = 4'd4,
      BRU_GE   = 4'd5,
      // unsigned compare
      BRU_LTU  = 4'd6,
      BRU_GEU  = 4'd7,
      // register indirect jump with link
      BRU_JIRL = 4'd8,
      // relative jumps, with and without link
      BRU_BL   = 4'd9,
      BRU_B    = 4'd10
   } bru_op_e;

endpackage

`default_nettype wire

// File: vlog.f
+incdir+bench
design/la_isa_pkg.sv
design/bru_pkg.sv
design/bru_req_if.sv
design/branch.sv
design/branch_issue.sv
design/branch_queue.sv
design/branch_retire.sv
design/branch_subsys.sv
bench/tb_branch_subsys.sv
